// ==== cpuDecode.sv ====
// ----------------------------------------
// CPU write decoder
// Single cycle strobe with no wait states
// Unmapped addresses are ignored
// ----------------------------------------
`timescale 1ns/1ns

module cpuDecode (
    input  logic                   M24,
    input  logic                   rstN,
    input  cpuRegPkg::cpuBus_t     cpu,
    output cpuRegPkg::regFile_t    regs,
    output vidTimingPkg::vramReq_t cpuReq
);
    import cpuRegPkg::*;

    logic        access;               // Write strobe this cycle
    logic        isVram;
    logic        isIrqEn;
    logic        isFlip;
    logic        upperBank;            // Address in chip 1
    logic [12:0] bankAddr;             // Address inside its chip
    regFile_t    regQ;
    logic [1:0]  reqCs;
    logic        reqWe;
    logic [12:0] reqAddr;
    logic [7:0]  reqData;

    // ----------------------------------------
    // Address decode
    // ----------------------------------------
    assign access    = cpu.cs && cpu.wr;
    assign isVram    = access && (cpu.addr <= vramTop);
    assign isIrqEn   = access && (cpu.addr == regIrqEnAddr);
    assign isFlip    = access && (cpu.addr == regFlipAddr);
    assign upperBank = (cpu.addr >= vramBankSize);
    assign bankAddr  = upperBank ? 13'(cpu.addr - vramBankSize) : cpu.addr[12:0];

    // Register file and request control
    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            regQ  <= '0;
            reqCs <= 2'b00;
            reqWe <= 1'b0;
        end else begin
            if (isIrqEn) regQ.irqEn <= cpu.data[2:0];   // Low 3 bits only
            if (isFlip)  regQ.flip  <= cpu.data[0];
            reqWe <= isVram;                            // One cycle request
            reqCs <= isVram ? (upperBank ? csBank1 : csBank0) : 2'b00;
        end
    end

    // Request payload
    always_ff @(posedge M24) begin
        if (isVram) begin
            reqAddr <= bankAddr;
            reqData <= cpu.data;
        end
    end

    assign regs   = regQ;
    assign cpuReq = '{addr: reqAddr, cs: reqCs, we: reqWe, data: reqData};

endmodule

// ==== cpuRegPkg.sv ====
// ----------------------------------------
// CPU bus and register map
// Only writes are modelled
// VRAM occupies 0x0000 to 0x17FF in two banks
// ----------------------------------------

package cpuRegPkg;

    // ----------------------------------------
    // CPU write cycle
    // ----------------------------------------
    typedef struct packed {
        logic        cs;               // Chip select
        logic        wr;               // Write strobe
        logic [15:0] addr;             // CPU address
        logic [7:0]  data;             // CPU write data
    } cpuBus_t;

    // ----------------------------------------
    // Register state seen by the video side
    // ----------------------------------------
    typedef struct packed {
        logic [2:0] irqEn;             // 2 IRQ / 1 FIRQ / 0 NMI
        logic       flip;              // Flip screen
    } regFile_t;

    // Register addresses
    localparam logic [15:0] regIrqEnAddr = 16'h1D00;  // Interrupt enables
    localparam logic [15:0] regFlipAddr  = 16'h1E80;  // Flip screen

    // VRAM window
    localparam logic [15:0] vramTop      = 16'h17FF;  // Last VRAM byte
    localparam logic [15:0] vramBankSize = 16'h0C00;  // Start of chip 1

    // Chip select encodings for CPU accesses
    localparam logic [1:0] csBank0 = 2'b01;           // Lower RAM
    localparam logic [1:0] csBank1 = 2'b10;           // Upper RAM

endpackage

// ==== irqControl.sv ====
// ----------------------------------------
// 6809 interrupt flags
// Outputs are active low
// A zero enable clears and holds its flag
// ----------------------------------------
`timescale 1ns/1ns

module irqControl (
    input  logic                   M24,
    input  logic                   rstN,
    input  vidTimingPkg::irqTrig_t trig,
    input  logic [2:0]             irqEn,
    output logic                   irqN,
    output logic                   firqN,
    output logic                   nmiN
);

    logic [2:0] trigVec;               // Same bit order as irqEn
    logic [2:0] flag;                  // High while pending

    assign trigVec = {trig.irq, trig.firq, trig.nmi};

    // ----------------------------------------
    // Set on trigger and clear on enable low
    // ----------------------------------------
    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            flag <= 3'b000;
        end else begin
            flag <= irqEn & (flag | trigVec);   // Sticky until disabled
        end
    end

    assign irqN  = ~flag[2];
    assign firqN = ~flag[1];
    assign nmiN  = ~flag[0];

endmodule

// ==== k052109.f ====
vidTimingPkg.sv
cpuRegPkg.sv
cpuDecode.sv
videoCounters.sv
irqControl.sv
vramAddrGen.sv
k052109Top.sv
k052109_checker.sv
k052109Tb.sv

// ==== k052109Tb.sv ====
// ----------------------------------------
// Testbench for the tile layer core
// Small geometry, one frame is 3840 cycles
// Outputs compared on the falling edge
// ----------------------------------------
`timescale 1ns/1ns

module k052109Tb;
    import cpuRegPkg::*;
    import vidTimingPkg::*;

    localparam int unsigned hTotal      = 48;
    localparam int unsigned vTotal      = 20;
    localparam int unsigned vBlankLine  = 16;
    localparam int unsigned pxDiv       = 4;
    localparam int unsigned frameCycles = hTotal * vTotal * pxDiv;

    logic        M24;
    logic        rstN;
    cpuBus_t     cpu;
    vramReq_t    vram;
    vidPos_t     pos;
    logic        hvot;
    logic        irqN;
    logic        firqN;
    logic        nmiN;

    // ---------------------------------------- Reference state
    vidPos_t     posM;                  // Expected pos this cycle
    vidPos_t     lastPos;               // Pos one cycle back
    irqTrig_t    trigM;
    logic [2:0]  flagM;                 // IRQ / FIRQ / NMI pending
    logic [2:0]  enM;
    logic        flipM;
    logic        lastFlip;
    vramReq_t    reqM;                  // Registered CPU request
    vramReq_t    lastReq;
    vramReq_t    expVram;
    logic        running;
    logic [15:0] rndAddr;

    k052109Top #(
        .hTotal(hTotal), .vTotal(vTotal), .vBlankLine(vBlankLine), .pxDiv(pxDiv)
    ) k052109Top_inst (
        .M24(M24), .rstN(rstN), .cpu(cpu), .vram(vram), .pos(pos),
        .hvot(hvot), .irqN(irqN), .firqN(firqN), .nmiN(nmiN)
    );

    initial M24 = 1'b0;
    always #4 M24 = ~M24;              // 8 ns period

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first failing check");
    endtask

    // Expected bus cycle for one fetch slot
    function automatic vramReq_t expectVram(vidPos_t p, logic flipV, vramReq_t req);
        vramReq_t r;
        if (req.we) return req;        // CPU write wins the slot
        r.cs          = 2'b11;
        r.we          = 1'b0;
        r.data        = 8'h00;
        r.addr[12:11] = p.phase[0] ? layerBCode : layerACode;
        r.addr[10:6]  = flipV ? ~p.vPos[7:3] : p.vPos[7:3];
        r.addr[5:0]   = flipV ? ~p.hPos[8:3] : p.hPos[8:3];
        return r;
    endfunction

    function automatic vramReq_t decodeWrite(cpuBus_t c);
        vramReq_t r;
        r = '0;
        if (c.cs && c.wr && (c.addr <= vramTop)) begin
            r.we   = 1'b1;
            r.cs   = (c.addr >= vramBankSize) ? 2'b10 : 2'b01;
            r.addr = (c.addr >= vramBankSize) ? 13'(c.addr - vramBankSize) : c.addr[12:0];
            r.data = c.data;
        end
        return r;
    endfunction

    // Moves the model one M24 edge ahead
    task automatic advanceModel();
        logic       newLine;
        logic [2:0] trigBits;
        newLine  = 1'b0;
        trigBits = {trigM.irq, trigM.firq, trigM.nmi};
        lastPos  = posM;
        lastFlip = flipM;
        lastReq  = reqM;
        for (int i = 0; i < 3; i++) begin
            if (!enM[i]) begin
                flagM[i] = 1'b0;       // Disabled flag held off
            end else if (trigBits[i]) begin
                flagM[i] = 1'b1;       // Set by its line trigger
            end
        end
        if (posM.phase == pxDiv - 1) begin
            posM.phase = 2'd0;
            if (posM.hPos == hTotal - 1) begin
                posM.hPos = 9'd0;
                newLine   = 1'b1;
                posM.vPos = (posM.vPos == vTotal - 1) ? 8'd0 : posM.vPos + 8'd1;
            end else begin
                posM.hPos++;
            end
        end else begin
            posM.phase++;
        end
        trigM.irq  = newLine && (posM.vPos == vBlankLine);
        trigM.firq = newLine && !posM.vPos[0];
        trigM.nmi  = newLine && (posM.vPos % nmiLineStep == 0);
        reqM = decodeWrite(cpu);
        if (cpu.cs && cpu.wr && cpu.addr == regIrqEnAddr) enM = cpu.data[2:0];
        if (cpu.cs && cpu.wr && cpu.addr == regFlipAddr) flipM = cpu.data[0];
    endtask

    // ---------------------------------------- Comparison
    always @(negedge M24) begin
        if (rstN) begin
            if (!running) begin        // First cycle out of reset
                assert (irqN && firqN && nmiN && !vram.we && vram.cs == 2'b00 && pos == '0)
                    else abortRun($sformatf("[ERROR] %0t outputs not at reset values", $time));
                running = 1'b1;
            end else begin
                expVram = expectVram(lastPos, lastFlip, lastReq);
                assert (vram === expVram)
                    else abortRun($sformatf("[ERROR] %0t vram is %h, expected %h",
                                            $time, vram, expVram));
            end
            assert (pos === posM)
                else abortRun($sformatf("[ERROR] %0t pos is %h, expected %h", $time, pos, posM));
            assert (hvot === (posM.vPos == vTotal - 1))
                else abortRun($sformatf("[ERROR] %0t hvot is %b on line %0d",
                                        $time, hvot, posM.vPos));
            assert ({irqN, firqN, nmiN} === ~flagM)
                else abortRun($sformatf("[ERROR] %0t interrupts are %b, expected %b",
                                        $time, {irqN, firqN, nmiN}, ~flagM));
            assert (k052109Top_inst.checkerInst.failCount == 0)
                else abortRun("A bound assertion on the DUT ports failed");
            advanceModel();
        end
    end

    // ---------------------------------------- Stimulus
    task automatic nextCycle();
        @(posedge M24);
        #1;                            // Drive just after the edge
    endtask

    task automatic cpuWrite(input logic [15:0] addr, input logic [7:0] data);
        cpu = '{cs: 1'b1, wr: 1'b1, addr: addr, data: data};
        nextCycle();
        cpu = '0;
    endtask

    task automatic waitLine(input int line);
        int n;
        n = 0;
        while (!(pos.vPos == line && pos.hPos == 0 && pos.phase == 0)) begin
            nextCycle();
            n++;
            if (n > 2 * frameCycles) abortRun($sformatf("Timed out waiting for line %0d", line));
        end
    endtask

    task automatic waitFlags(input logic [2:0] level);
        int n;
        n = 0;
        while ({irqN, firqN, nmiN} !== level) begin
            nextCycle();
            n++;
            if (n > 2 * frameCycles)
                abortRun($sformatf("Timed out waiting for interrupt outputs %b", level));
        end
    endtask

    initial begin
        cpu        = '0;
        rstN       = 1'b0;
        running    = 1'b0;
        {posM, lastPos, trigM, flagM, enM, flipM, lastFlip, reqM, lastReq} = '0;
        void'($urandom(32'hd515));
        repeat (16) @(posedge M24);
        #1;
        rstN = 1'b1;
        waitLine(vTotal - 1);          // One full frame, flip off
        waitLine(0);
        cpuWrite(regFlipAddr, 8'h01);
        waitLine(vTotal / 2);
        for (int i = 0; i < 60; i++) begin
            rndAddr = 16'($urandom_range(vramTop, 0));
            cpuWrite(rndAddr, 8'($urandom));
            if ($urandom_range(1, 0)) nextCycle();    // Idle gap
        end
        cpuWrite(16'h2000, 8'h55);     // Unmapped, ignored
        cpuWrite(regFlipAddr, 8'h00);
        cpuWrite(regIrqEnAddr, 8'h07);
        waitFlags(3'b000);
        cpuWrite(regIrqEnAddr, 8'h00);
        waitFlags(3'b111);
        waitLine(0);                   // Lines pass with enables off
        if (k052109Top_inst.checkerInst.failCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== k052109Top.sv ====
// ----------------------------------------
// Tile layer generator core
// Single clock domain on M24
// CPU side is write only
// ----------------------------------------
`timescale 1ns/1ns

module k052109Top #(
    parameter int unsigned hTotal     = 384,
    parameter int unsigned vTotal     = 264,
    parameter int unsigned vBlankLine = 240,
    parameter int unsigned pxDiv      = 4
) (
    input  logic                   M24,
    input  logic                   rstN,
    input  cpuRegPkg::cpuBus_t     cpu,
    output vidTimingPkg::vramReq_t vram,
    output vidTimingPkg::vidPos_t  pos,
    output logic                   hvot,
    output logic                   irqN,
    output logic                   firqN,
    output logic                   nmiN
);
    import cpuRegPkg::*;
    import vidTimingPkg::*;

    regFile_t regs;                    // Control registers
    vramReq_t cpuReq;                  // Registered CPU VRAM write
    irqTrig_t trig;                    // Line triggers

    cpuDecode cpuDecode_inst (
        .M24    (M24),
        .rstN   (rstN),
        .cpu    (cpu),
        .regs   (regs),
        .cpuReq (cpuReq)
    );

    videoCounters #(
        .hTotal     (hTotal),
        .vTotal     (vTotal),
        .vBlankLine (vBlankLine),
        .pxDiv      (pxDiv)
    ) videoCounters_inst (
        .M24  (M24),
        .rstN (rstN),
        .pos  (pos),
        .trig (trig),
        .hvot (hvot)
    );

    irqControl irqControl_inst (
        .M24   (M24),
        .rstN  (rstN),
        .trig  (trig),
        .irqEn (regs.irqEn),
        .irqN  (irqN),
        .firqN (firqN),
        .nmiN  (nmiN)
    );

    vramAddrGen vramAddrGen_inst (
        .M24    (M24),
        .rstN   (rstN),
        .pos    (pos),
        .flip   (regs.flip),
        .cpuReq (cpuReq),
        .vram   (vram)
    );

endmodule

// ==== k052109_checker.sv ====
// ----------------------------------------
// Port level properties of the tile core
// Sampled on M24 and idle during reset
// failCount is read back by the testbench
// ----------------------------------------
`timescale 1ns/1ns

module k052109_checker #(
    parameter int unsigned hTotal = 384,
    parameter int unsigned pxDiv  = 4
) (
    input logic                   M24,
    input logic                   rstN,
    input cpuRegPkg::cpuBus_t     cpu,
    input vidTimingPkg::vramReq_t vram,
    input vidTimingPkg::vidPos_t  pos,
    input logic [2:0]             irqEn,
    input logic                   irqN,
    input logic                   firqN,
    input logic                   nmiN
);
    import cpuRegPkg::*;

    int failCount = 0;                 // Failed assertions so far

    hPosRange: assert property (@(posedge M24) disable iff (!rstN)
        pos.hPos < hTotal)
        else begin $error("hPos reached hTotal"); failCount++; end

    // Pixel step on the last divider cycle
    hPosStep: assert property (@(posedge M24) disable iff (!rstN)
        (pos.phase == 2'(pxDiv - 1)) |=>
        (pos.hPos == (($past(pos.hPos) == hTotal - 1) ? 9'd0 : $past(pos.hPos) + 9'd1)))
        else begin $error("hPos did not advance on a phase wrap"); failCount++; end

    weOrigin: assert property (@(posedge M24) disable iff (!rstN)
        $rose(vram.we) |-> $past(cpu.cs && cpu.wr && (cpu.addr <= vramTop), 2))
        else begin $error("vram we rose without a CPU VRAM write"); failCount++; end

    // Flags lag their enable by one edge
    irqMasked: assert property (@(posedge M24) disable iff (!rstN)
        ({irqN, firqN, nmiN} | $past(irqEn)) == 3'b111)
        else begin $error("Interrupt asserted while disabled"); failCount++; end

endmodule

bind k052109Top k052109_checker #(.hTotal(hTotal), .pxDiv(pxDiv)) checkerInst (
    .M24(M24), .rstN(rstN), .cpu(cpu), .vram(vram), .pos(pos),
    .irqEn(regs.irqEn), .irqN(irqN), .firqN(firqN), .nmiN(nmiN)
);

// ==== vidTimingPkg.sv ====
// ----------------------------------------
// Beam geometry and video side types
// Position fields are sized for up to 512 pixels and 256 lines
// Phase is 2 bits so the pixel divider is limited to 4
// ----------------------------------------

package vidTimingPkg;

    // ----------------------------------------
    // Beam position
    // ----------------------------------------
    typedef struct packed {
        logic [8:0] hPos;              // Pixel in line
        logic [7:0] vPos;              // Line in frame
        logic [1:0] phase;             // M24 cycle inside pixel
    } vidPos_t;

    // ----------------------------------------
    // VRAM bus cycle
    // ----------------------------------------
    typedef struct packed {
        logic [12:0] addr;             // Bank relative address
        logic [1:0]  cs;               // One hot per RAM chip
        logic        we;               // High on CPU write only
        logic [7:0]  data;             // Write data
    } vramReq_t;

    // One cycle pulses from the line counter
    typedef struct packed {
        logic irq;                     // Vertical blank line
        logic firq;                    // Even lines
        logic nmi;                     // Every nmiLineStep lines
    } irqTrig_t;

    localparam logic [1:0] layerACode = 2'b01;   // Fetch for layer A
    localparam logic [1:0] layerBCode = 2'b10;   // Fetch for layer B

    localparam int unsigned nmiLineStep = 8;     // NMI line spacing

endpackage

// ==== videoCounters.sv ====
// ----------------------------------------
// Pixel divider and beam counters
// pxDiv must be 2 or 4
// hTotal up to 512 and vTotal up to 256
// Trigger pulses follow each new line by one cycle
// ----------------------------------------
`timescale 1ns/1ns

module videoCounters #(
    parameter int unsigned hTotal     = 384,
    parameter int unsigned vTotal     = 264,
    parameter int unsigned vBlankLine = 240,
    parameter int unsigned pxDiv      = 4
) (
    input  logic                   M24,
    input  logic                   rstN,
    output vidTimingPkg::vidPos_t  pos,
    output vidTimingPkg::irqTrig_t trig,
    output logic                   hvot
);
    import vidTimingPkg::*;

    localparam logic [1:0] phaseLast = 2'(pxDiv - 1);     // Last M24 cycle of a pixel
    localparam logic [8:0] hLast     = 9'(hTotal - 1);    // Last pixel of a line
    localparam logic [7:0] vLast     = 8'(vTotal - 1);    // Last line of a frame
    localparam logic [7:0] irqLine   = 8'(vBlankLine);

    logic [1:0] phase;
    logic [8:0] hPos;
    logic [7:0] vPos;
    logic [7:0] vNext;                 // Line after the current one
    logic       pxTick;                // Phase wraps this cycle
    logic       lineEnd;               // Line wraps this cycle
    irqTrig_t   trigQ;

    assign pxTick  = (phase == phaseLast);
    assign lineEnd = pxTick && (hPos == hLast);
    assign vNext   = (vPos == vLast) ? 8'd0 : vPos + 8'd1;

    // ----------------------------------------
    // Counters
    // ----------------------------------------
    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            phase <= 2'd0;
            hPos  <= 9'd0;
            vPos  <= 8'd0;
        end else begin
            phase <= pxTick ? 2'd0 : phase + 2'd1;
            if (pxTick) begin
                hPos <= (hPos == hLast) ? 9'd0 : hPos + 9'd1;
            end
            if (lineEnd) begin
                vPos <= vNext;         // Same edge as the hPos wrap
            end
        end
    end

    // ----------------------------------------
    // Interrupt triggers
    // ----------------------------------------
    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            trigQ <= '0;
        end else begin
            trigQ <= '0;               // Pulses last one cycle
            if (lineEnd) begin
                trigQ.irq  <= (vNext == irqLine);
                trigQ.firq <= ~vNext[0];                            // Even line
                trigQ.nmi  <= ((vNext % 8'(nmiLineStep)) == 8'd0);
            end
        end
    end

    assign trig = trigQ;
    assign pos  = '{hPos: hPos, vPos: vPos, phase: phase};
    assign hvot = (vPos == vLast);     // Whole last line of the frame

endmodule

// ==== vramAddrGen.sv ====
// ----------------------------------------
// VRAM bus generator
// A CPU write takes the slot of that fetch
// The lost fetch is not retried
// Rendering alternates layers every M24 cycle
// ----------------------------------------
`timescale 1ns/1ns

module vramAddrGen (
    input  logic                   M24,
    input  logic                   rstN,
    input  vidTimingPkg::vidPos_t  pos,
    input  logic                   flip,
    input  vidTimingPkg::vramReq_t cpuReq,
    output vidTimingPkg::vramReq_t vram
);
    import vidTimingPkg::*;

    logic [1:0] layerCode;
    logic [4:0] rowSel;                // Tile row in map
    logic [5:0] colSel;                // Tile column in map
    vramReq_t   renderReq;

    // ----------------------------------------
    // Rendering fetch
    // ----------------------------------------
    assign layerCode = pos.phase[0] ? layerBCode : layerACode;
    assign rowSel    = pos.vPos[7:3] ^ {5{flip}};     // 8 line tiles
    assign colSel    = pos.hPos[8:3] ^ {6{flip}};     // 8 pixel tiles

    assign renderReq = '{
        addr: {layerCode, rowSel, colSel},
        cs:   2'b11,                   // Both chips read
        we:   1'b0,
        data: 8'h00
    };

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge M24 or negedge rstN) begin
        if (!rstN) begin
            vram <= '0;
        end else if (cpuReq.we) begin
            vram <= cpuReq;            // CPU has priority
        end else begin
            vram <= renderReq;
        end
    end

endmodule
